// File: verilog/tile_params.svh
// Tile size parameters
`ifndef TILE_PARAMS_SVH
`define TILE_PARAMS_SVH

// Weight buffer geometry, one 16x1024 block RAM
`define TILE_W_WIDTH      16
`define TILE_W_ADDR_W     10

// Activation buffer, two banks of 32 words
`define TILE_ACT_WIDTH    16
`define TILE_ACT_ADDR_W   6    // Includes the bank bit in the LSB

// Accumulator path
`define TILE_ACC_WIDTH    48

// Issue edge to p_valid, in clk_h cycles
`define TILE_MAC_LATENCY  4

`endif

// File: verilog/tile_pkg.sv
// Tile shared types
`include "tile_params.svh"

package tile_pkg;

   // Data words, both multiplier operands are signed
   typedef logic signed [`TILE_W_WIDTH-1:0]   weight_t;
   typedef logic signed [`TILE_ACT_WIDTH-1:0] act_t;

   // Accumulator wraps modulo 2^48
   typedef logic [`TILE_ACC_WIDTH-1:0]        acc_t;

   // Addresses
   typedef logic [`TILE_W_ADDR_W-1:0]         w_addr_t;
   typedef logic [`TILE_ACT_ADDR_W-2:0]       act_haddr_t;  // Bank bit excluded

   // Addend source opcode, chosen per operation
   typedef enum logic {
      ACC_SUM = 1'b0,    // External partial sum
      ACC_CAS = 1'b1     // Cascade from previous tile
   } acc_src_e;

   // Four-phase weight write handshake
   typedef enum logic {
      W_IDLE = 1'b0,     // Waiting for req
      W_ACK  = 1'b1      // Word written, ack held until req drops
   } w_wr_state_e;

endpackage

// File: verilog/mac_op_if.sv
// MAC operand interface
`timescale 1ns/1ps

interface mac_op_if;
   import tile_pkg::*;

   logic     op_valid;    // Operands below are aligned this cycle
   weight_t  op_weight;   // From weight buffer output register
   act_t     op_act;      // From activation buffer align stage
   acc_src_e op_src;      // Addend source travelling with the operands

   // Weight buffer owns the weight operand only
   modport weight_src (
      output op_weight
   );

   // Activation buffer owns timing and opcode
   modport act_src (
      output op_valid,
      output op_act,
      output op_src
   );

   modport mac (
      input op_valid,
      input op_weight,
      input op_act,
      input op_src
   );

endinterface

// File: verilog/weight_buffer.sv
// Weight buffer
`timescale 1ns/1ps
`include "tile_params.svh"

module weight_buffer (
   input  logic              clk_h,
   input  logic              rst_n,
   input  logic              w_wr_req,     // Four-phase request from host
   input  tile_pkg::w_addr_t w_wr_addr,    // Held stable while req is high
   input  tile_pkg::weight_t w_wr_data,
   output logic              w_wr_ack,
   input  tile_pkg::w_addr_t w_rd_addr,    // Sampled every cycle
   mac_op_if.weight_src      op
);
   import tile_pkg::*;

   localparam int DEPTH = 1 << `TILE_W_ADDR_W;

   weight_t     mem [DEPTH];     // 1024 x 16 array
   w_wr_state_e wr_state;
   logic        wr_fire;         // Single write per handshake
   w_addr_t     rd_addr_q;       // Address sampled at issue
   weight_t     rd_data_q;       // Array output register

   // Write only on the first cycle req is seen in idle
   assign wr_fire  = (wr_state == W_IDLE) && w_wr_req;
   assign w_wr_ack = (wr_state == W_ACK);

   // Handshake FSM
   always_ff @(posedge clk_h or negedge rst_n) begin
      if (!rst_n) begin
         wr_state <= W_IDLE;
      end else begin
         case (wr_state)
            W_IDLE: begin
               if (wr_fire) begin
                  wr_state <= W_ACK;     // Ack rises with the write edge
               end
            end
            W_ACK: begin
               if (!w_wr_req) begin
                  wr_state <= W_IDLE;    // Host released req
               end
            end
            default: begin
               wr_state <= W_IDLE;
            end
         endcase
      end
   end

   // Array write port
   always_ff @(posedge clk_h) begin
      if (wr_fire) begin
         mem[w_wr_addr] <= w_wr_data;
      end
   end

   // Read pipeline, address then array then output register
   // A write to the same word on the array-read edge returns the old word
   always_ff @(posedge clk_h) begin
      rd_addr_q    <= w_rd_addr;         // Cycle 0
      rd_data_q    <= mem[rd_addr_q];    // Cycle 1
      op.op_weight <= rd_data_q;         // Cycle 2, aligned with activation
   end

endmodule

// File: verilog/act_buffer.sv
// Activation buffer
`timescale 1ns/1ps
`include "tile_params.svh"

module act_buffer (
   input  logic                 clk_h,
   input  logic                 rst_n,
   input  logic                 act_wr_en,      // One-cycle write pulse
   input  tile_pkg::act_haddr_t act_wr_addr,
   input  tile_pkg::act_t       act_wr_data,
   input  logic                 calc_valid,     // One-cycle issue pulse
   input  tile_pkg::act_haddr_t act_rd_addr,
   input  tile_pkg::acc_src_e   acc_src,
   mac_op_if.act_src            op
);
   import tile_pkg::*;

   localparam int DEPTH = 1 << `TILE_ACT_ADDR_W;

   act_t     mem [DEPTH];   // Bank bit is the address LSB
   logic     wr_bank;       // Flips on each activation write
   logic     rd_bank;       // Flips on each issued operation
   act_t     act_q0;
   act_t     act_q1;
   logic     valid_q0;
   logic     valid_q1;
   acc_src_e src_q0;
   acc_src_e src_q1;

   // Bank bits
   always_ff @(posedge clk_h or negedge rst_n) begin
      if (!rst_n) begin
         wr_bank <= 1'b0;
         rd_bank <= 1'b0;
      end else begin
         if (act_wr_en) begin
            wr_bank <= ~wr_bank;
         end
         if (calc_valid) begin
            rd_bank <= ~rd_bank;
         end
      end
   end

   // Write port uses the bank before it flips
   always_ff @(posedge clk_h) begin
      if (act_wr_en) begin
         mem[{act_wr_addr, wr_bank}] <= act_wr_data;
      end
   end

   // Combinational read captured at issue, so a same-edge write gives the old word
   always_ff @(posedge clk_h) begin
      act_q0    <= mem[{act_rd_addr, rd_bank}];  // Cycle 0
      act_q1    <= act_q0;                       // Cycle 1
      op.op_act <= act_q1;                       // Cycle 2, with weight
      src_q0    <= acc_src;
      src_q1    <= src_q0;
      op.op_src <= src_q1;
   end

   // Valid follows the same stages
   always_ff @(posedge clk_h or negedge rst_n) begin
      if (!rst_n) begin
         valid_q0    <= 1'b0;
         valid_q1    <= 1'b0;
         op.op_valid <= 1'b0;
      end else begin
         valid_q0    <= calc_valid;
         valid_q1    <= valid_q0;
         op.op_valid <= valid_q1;
      end
   end

endmodule

// File: verilog/mac_slice.sv
// MAC slice
`timescale 1ns/1ps
`include "tile_params.svh"

module mac_slice (
   input  logic               clk_h,
   input  logic               rst_n,
   input  tile_pkg::acc_t     p_sumin,     // External partial sum
   input  tile_pkg::acc_t     p_casin,     // Cascade from previous tile
   input  logic               calc_valid,
   input  tile_pkg::acc_src_e acc_src,
   mac_op_if.mac              op,
   output tile_pkg::acc_t     p_out,
   output tile_pkg::acc_t     p_casout,
   output logic               p_valid
);
   import tile_pkg::*;

   localparam int ADD_DLY = `TILE_MAC_LATENCY - 1;           // Issue to operand stage
   localparam int PROD_W  = `TILE_W_WIDTH + `TILE_ACT_WIDTH;
   localparam int ACC_W   = `TILE_ACC_WIDTH;

   acc_t                     sum_d [ADD_DLY];   // Partial sum addend line
   acc_t                     cas_d [ADD_DLY];   // Cascade addend line
   logic signed [PROD_W-1:0] prod;
   acc_t                     prod_m;            // Product register, cycle 3
   acc_t                     add_m;             // Addend register, cycle 3
   acc_t                     p_reg;             // Result register, cycle 4
   logic                     valid_m;

   assign prod = op.op_weight * op.op_act;      // Full signed 32-bit product

   // Only the source named by acc_src is captured at issue
   always_ff @(posedge clk_h) begin
      if (calc_valid && (acc_src == ACC_SUM)) begin
         sum_d[0] <= p_sumin;
      end
      if (calc_valid && (acc_src == ACC_CAS)) begin
         cas_d[0] <= p_casin;
      end
      for (int i = 1; i < ADD_DLY; i++) begin
         sum_d[i] <= sum_d[i-1];
         cas_d[i] <= cas_d[i-1];
      end
   end

   // Multiply stage, addend picked by the opcode that came with the operands
   always_ff @(posedge clk_h) begin
      prod_m <= ACC_W'(prod);                    // Sign extended
      add_m  <= (op.op_src == ACC_CAS) ? cas_d[ADD_DLY-1] : sum_d[ADD_DLY-1];
   end

   // Add stage, p_reg holds while idle
   always_ff @(posedge clk_h or negedge rst_n) begin
      if (!rst_n) begin
         valid_m <= 1'b0;
         p_valid <= 1'b0;
         p_reg   <= '0;
      end else begin
         valid_m <= op.op_valid;
         p_valid <= valid_m;
         if (valid_m) begin
            p_reg <= prod_m + add_m;             // Wraps modulo 2^48
         end
      end
   end

   // One result drives both the primary and the cascade output
   assign p_out    = p_reg;
   assign p_casout = p_reg;

endmodule

// File: verilog/stile.sv
// Systolic compute tile
`timescale 1ns/1ps

module stile (
   input  logic                 clk_h,
   input  logic                 rst_n,
   // Weight load, four-phase handshake
   input  logic                 w_wr_req,
   input  tile_pkg::w_addr_t    w_wr_addr,
   input  tile_pkg::weight_t    w_wr_data,
   output logic                 w_wr_ack,
   // Activation load
   input  logic                 act_wr_en,
   input  tile_pkg::act_haddr_t act_wr_addr,
   input  tile_pkg::act_t       act_wr_data,
   // Operation issue
   input  logic                 calc_valid,
   input  tile_pkg::w_addr_t    w_rd_addr,
   input  tile_pkg::act_haddr_t act_rd_addr,
   input  tile_pkg::acc_src_e   acc_src,
   // Accumulator chain
   input  tile_pkg::acc_t       p_sumin,
   input  tile_pkg::acc_t       p_casin,
   output tile_pkg::acc_t       p_out,
   output tile_pkg::acc_t       p_casout,
   output logic                 p_valid
);

   mac_op_if op_if ();   // Buffer operands into the MAC

   weight_buffer i_weight_buffer (
      .clk_h     (clk_h),
      .rst_n     (rst_n),
      .w_wr_req  (w_wr_req),
      .w_wr_addr (w_wr_addr),
      .w_wr_data (w_wr_data),
      .w_wr_ack  (w_wr_ack),
      .w_rd_addr (w_rd_addr),
      .op        (op_if.weight_src)
   );

   act_buffer i_act_buffer (
      .clk_h       (clk_h),
      .rst_n       (rst_n),
      .act_wr_en   (act_wr_en),
      .act_wr_addr (act_wr_addr),
      .act_wr_data (act_wr_data),
      .calc_valid  (calc_valid),
      .act_rd_addr (act_rd_addr),
      .acc_src     (acc_src),
      .op          (op_if.act_src)
   );

   mac_slice i_mac_slice (
      .clk_h      (clk_h),
      .rst_n      (rst_n),
      .p_sumin    (p_sumin),
      .p_casin    (p_casin),
      .calc_valid (calc_valid),
      .acc_src    (acc_src),
      .op         (op_if.mac),
      .p_out      (p_out),
      .p_casout   (p_casout),
      .p_valid    (p_valid)
   );

endmodule

// File: dv/tb_clkgen.sv
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clkgen (
   output logic clk_h,
   output logic rst_n
);
   localparam time HALF_PERIOD = 50ns;   // 100 ns clock

   initial clk_h = 1'b0;
   always #(HALF_PERIOD) clk_h = ~clk_h;

   // Reset held low for three rising edges
   initial begin
      rst_n = 1'b0;
      repeat (3) @(posedge clk_h);
      rst_n <= 1'b1;
   end

endmodule

// File: dv/tb_stile.sv
// Compute tile testbench
`timescale 1ns/1ps
`include "tile_params.svh"

module tb_stile;
   import tile_pkg::*;

   localparam int LAT     = `TILE_MAC_LATENCY;
   localparam int N_WW    = 20;    // Weight writes
   localparam int N_AW    = 66;    // Activation writes, two plus a full fill of both banks
   localparam int N_OP    = 34;    // Issued operations
   localparam int TIMEOUT = 8*N_WW + 2*N_AW + N_OP + 50;

   logic       clk_h;
   logic       rst_n;
   logic       w_wr_req;
   w_addr_t    w_wr_addr;
   weight_t    w_wr_data;
   logic       w_wr_ack;
   logic       act_wr_en;
   act_haddr_t act_wr_addr;
   act_t       act_wr_data;
   logic       calc_valid;
   w_addr_t    w_rd_addr;
   act_haddr_t act_rd_addr;
   acc_src_e   acc_src;
   acc_t       p_sumin;
   acc_t       p_casin;
   acc_t       p_out;
   acc_t       p_casout;
   logic       p_valid;

   integer  seed = 25;
   int      cyc = 0;              // Rising edges since time 0
   weight_t w_shadow [1024];      // Model copy of the weight array
   act_t    a_shadow [64];        // Model copy with the bank bit in the LSB
   logic    wr_bank_m = 1'b0;
   logic    rd_bank_m = 1'b0;
   w_addr_t w_used [N_WW];        // Addresses that hold known weights
   acc_t    exp_q [$];            // Expected results in issue order
   int      issue_q [$];          // Sampling edge of each issue
   acc_t    last_out = '0;

   tb_clkgen i_clkgen (
      .clk_h (clk_h),
      .rst_n (rst_n)
   );

   stile i_stile (
      .clk_h       (clk_h),
      .rst_n       (rst_n),
      .w_wr_req    (w_wr_req),
      .w_wr_addr   (w_wr_addr),
      .w_wr_data   (w_wr_data),
      .w_wr_ack    (w_wr_ack),
      .act_wr_en   (act_wr_en),
      .act_wr_addr (act_wr_addr),
      .act_wr_data (act_wr_data),
      .calc_valid  (calc_valid),
      .w_rd_addr   (w_rd_addr),
      .act_rd_addr (act_rd_addr),
      .acc_src     (acc_src),
      .p_sumin     (p_sumin),
      .p_casin     (p_casin),
      .p_out       (p_out),
      .p_casout    (p_casout),
      .p_valid     (p_valid)
   );

   // Signed product sign extended to 48 bits plus the chosen addend
   function automatic acc_t mac_ref(input weight_t w, input act_t a, input acc_src_e src,
                                    input acc_t sumin, input acc_t casin);
      logic signed [31:0] prod;
      acc_t               prod_ext;
      prod     = w * a;
      prod_ext = {{16{prod[31]}}, prod};
      return prod_ext + ((src == ACC_CAS) ? casin : sumin);   // Wraps at 2^48
   endfunction

   function logic [31:0] rand32();
      rand32 = $random(seed);
   endfunction

   function acc_t rand48();
      logic [31:0] hi;
      hi     = rand32();
      rand48 = {hi[15:0], rand32()};
   endfunction

   task automatic fail_msg(input string what);
      $display("%s", what);
      $display("Test failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_acc(input string name, input acc_t got, input acc_t exp);
      if (got !== exp) begin
         fail_msg($sformatf("[FAIL] %s got 0x%012h expected 0x%012h", name, got, exp));
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         fail_msg($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp));
      end
   endtask

   // Four-phase weight write with ack checked in each phase
   task automatic write_weight(input w_addr_t addr, input weight_t data);
      int n;
      @(posedge clk_h);
      w_wr_req  <= 1'b1;
      w_wr_addr <= addr;
      w_wr_data <= data;
      w_shadow[addr] = data;
      @(negedge clk_h);
      check_bit("w_wr_ack", w_wr_ack, 1'b0);   // Req not sampled yet
      @(negedge clk_h);
      check_bit("w_wr_ack", w_wr_ack, 1'b1);   // Up on the edge that sees req
      @(posedge clk_h);
      w_wr_req <= 1'b0;
      n = 0;
      do begin
         @(negedge clk_h);
         n++;
      end while (w_wr_ack && n < 4);
      if (w_wr_ack) begin
         fail_msg("Weight write handshake stuck, w_wr_ack stayed high after req dropped");
      end else if (n != 2) begin
         fail_msg($sformatf("w_wr_ack dropped %0d cycles after req, expected 2", n));
      end
   endtask

   task automatic write_act(input act_haddr_t addr, input act_t data);
      @(posedge clk_h);
      act_wr_en   <= 1'b1;
      act_wr_addr <= addr;
      act_wr_data <= data;
   endtask

   task automatic issue_op(input w_addr_t wa, input act_haddr_t aa, input acc_src_e src,
                           input acc_t sumin, input acc_t casin);
      @(posedge clk_h);
      calc_valid  <= 1'b1;
      w_rd_addr   <= wa;
      act_rd_addr <= aa;
      acc_src     <= src;
      p_sumin     <= sumin;
      p_casin     <= casin;
   endtask

   task automatic idle_inputs();
      @(posedge clk_h);
      act_wr_en  <= 1'b0;
      calc_valid <= 1'b0;
   endtask

   // Wait until every issued result has been compared
   task automatic drain();
      while (exp_q.size() != 0) @(negedge clk_h);
   endtask

   // Reference model samples the stable inputs at the falling edge
   always @(negedge clk_h) begin
      if (!rst_n) begin
         wr_bank_m = 1'b0;
         rd_bank_m = 1'b0;
      end else begin
         if (calc_valid) begin   // Read before the write so a same-cycle write gives the old word
            exp_q.push_back(mac_ref(w_shadow[w_rd_addr], a_shadow[{act_rd_addr, rd_bank_m}],
                                    acc_src, p_sumin, p_casin));
            issue_q.push_back(cyc + 1);
            rd_bank_m = ~rd_bank_m;
         end
         if (act_wr_en) begin
            a_shadow[{act_wr_addr, wr_bank_m}] = act_wr_data;
            wr_bank_m = ~wr_bank_m;
         end
      end
   end

   // Result compare
   always @(negedge clk_h) begin : compare_results
      int   lat;
      acc_t exp_val;
      if (rst_n) begin
         if (p_valid) begin
            if (exp_q.size() == 0) begin
               fail_msg("p_valid rose with no operation in flight");
            end else begin
               lat = cyc - issue_q[0];
               if (lat != LAT) begin
                  fail_msg($sformatf("p_valid came %0d cycles after issue, expected %0d",
                                     lat, LAT));
               end
               exp_val = exp_q.pop_front();
               void'(issue_q.pop_front());
               check_acc("p_out", p_out, exp_val);
               check_acc("p_casout", p_casout, exp_val);
               last_out = exp_val;
            end
         end else begin
            check_acc("p_out", p_out, last_out);      // Holds while idle
            if (issue_q.size() != 0 && cyc - issue_q[0] > LAT) begin
               fail_msg("p_valid missing for an issued operation");
            end
         end
      end
   end

   always @(posedge clk_h) begin
      cyc <= cyc + 1;
      if (cyc > TIMEOUT) begin
         fail_msg($sformatf("Timeout, run went past %0d cycles", TIMEOUT));
      end
   end

   initial begin
      logic [31:0] r;
      weight_t     wd;
      acc_t        big;
      w_wr_req    = 1'b0;
      w_wr_addr   = '0;
      w_wr_data   = '0;
      act_wr_en   = 1'b0;
      act_wr_addr = '0;
      act_wr_data = '0;
      calc_valid  = 1'b0;
      w_rd_addr   = '0;
      act_rd_addr = '0;
      acc_src     = ACC_SUM;
      p_sumin     = '0;
      p_casin     = '0;

      @(posedge rst_n);
      @(negedge clk_h);
      check_bit("p_valid", p_valid, 1'b0);
      check_bit("w_wr_ack", w_wr_ack, 1'b0);
      check_acc("p_out", p_out, '0);
      check_acc("p_casout", p_casout, '0);

      // Weight load with the extremes first
      for (int i = 0; i < N_WW; i++) begin
         r = rand32();
         w_used[i] = r[9:0];
         wd = (i == 0) ? 16'h8000 : (i == 1) ? 16'h7FFF : (i == 2) ? 16'hFFFF : r[25:10];
         write_weight(w_used[i], wd);
      end

      // Same address written into banks 0 and 1 and read back in write order
      write_act(5'd5, 16'h8001);
      write_act(5'd5, 16'h7FFF);
      idle_inputs();
      issue_op(w_used[0], 5'd5, ACC_SUM, '0, rand48());
      issue_op(w_used[1], 5'd5, ACC_SUM, '0, rand48());
      idle_inputs();
      drain();

      // Each address twice so both banks hold known words
      for (int i = 0; i < N_AW - 2; i++) begin
         r = rand32();
         write_act(act_haddr_t'(i / 2), r[31:16]);
      end
      idle_inputs();

      // Partial sum addend
      for (int i = 0; i < 8; i++) begin
         r = rand32();
         issue_op(w_used[i % N_WW], r[4:0], ACC_SUM, rand48(), rand48());
      end
      idle_inputs();
      drain();

      // Cascade addend near the 48-bit limits
      for (int i = 0; i < 8; i++) begin
         r = rand32();
         case (i % 4)
            0:       big = 48'hFFFF_FFFF_FFFF;
            1:       big = 48'h8000_0000_0000;
            2:       big = 48'h7FFF_FFFF_FFFF;
            default: big = '0;
         endcase
         issue_op(w_used[(i + 3) % N_WW], r[4:0], ACC_CAS, rand48(), big);
      end
      idle_inputs();
      drain();

      // 16 back to back issues with mixed opcodes
      for (int i = 0; i < 16; i++) begin
         r = rand32();
         issue_op(w_used[int'(r[15:8]) % N_WW], r[5:1], acc_src_e'(r[0]), rand48(), rand48());
      end
      idle_inputs();
      drain();

      $display("Test passed");
      $finish;
   end

endmodule

// File: filelist.f
+incdir+verilog
verilog/tile_pkg.sv
verilog/mac_op_if.sv
verilog/weight_buffer.sv
verilog/act_buffer.sv
verilog/mac_slice.sv
verilog/stile.sv
dv/tb_clkgen.sv
dv/tb_stile.sv

// File: Makefile
TOP := tb_stile

.PHONY: sim clean

sim:
	verilator --binary --timing -sv -Wno-fatal -f filelist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
